//--- dvk_board.f
hdl/dvk_board_pkg.sv
hdl/board_ram.sv
hdl/ram_bus_slave.sv
hdl/button_filter.sv
hdl/vga_dac_drive.sv
hdl/dvk_board_top.sv
tests/tb_dvk_board.sv

//--- hdl/board_ram.sv
// 64 KB on-chip word memory
// byte lane write enables, registered read port
`timescale 1ns/1ps
`default_nettype none

module board_ram (
   input  logic                              clk_p,
   input  logic [dvk_board_pkg::ram_aw-1:0]  addr,     // word address
   input  logic [dvk_board_pkg::ram_sw-1:0]  byte_en,  // one bit per byte lane
   input  logic [dvk_board_pkg::ram_dw-1:0]  wdata,
   input  logic                              rd_en,
   input  logic                              wr_en,
   output logic [dvk_board_pkg::ram_dw-1:0]  rdata     // valid the cycle after rd_en
);
   import dvk_board_pkg::*;

   //******************************
   // storage
   //******************************
   logic [ram_dw-1:0] mem [0:(1 << ram_aw) - 1];  // 32K words

   // write port, lanes updated independently
   always_ff @(posedge clk_p) begin
      if (wr_en) begin
         for (int i = 0; i < ram_sw; i++) begin
            if (byte_en[i]) begin
               mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];  // enabled lane only
            end
         end
      end
   end

   // read port, output register holds between reads
   always_ff @(posedge clk_p) begin
      if (rd_en) begin
         rdata <= mem[addr];
      end
   end

endmodule : board_ram

`default_nettype wire

//--- hdl/button_filter.sv
// board button conditioning
// two-flop synchronizer and debounce filter per button
// level controls, toggle for the timer button
`timescale 1ns/1ps
`default_nettype none

module button_filter (
   input  logic                             clk_p,
   input  logic                             arst_n,
   input  logic [dvk_board_pkg::btn_n-1:0]  btn_n_in,   // raw pins, low = pressed
   output logic                             sys_reset,
   output logic                             halt_req,
   output logic                             term_reset,
   output logic                             timer_on
);
   import dvk_board_pkg::*;

   logic [btn_n-1:0]      sync_a;        // first sync stage
   logic [btn_n-1:0]      sync_b;        // second sync stage
   filt_state_t           state [btn_n];
   logic [debounce_w-1:0] cnt [btn_n];   // settle counter
   logic [btn_n-1:0]      level_n;       // accepted level, low = pressed
   logic [btn_n-1:0]      pressed;       // active-high accepted level
   logic                  timer_prev;    // last accepted level of button 3

   //******************************
   // synchronizer
   //******************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         sync_a <= '1;                   // released
         sync_b <= '1;
      end else begin
         sync_a <= btn_n_in;
         sync_b <= sync_a;
      end
   end

   //******************************
   // debounce
   //******************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         level_n <= '1;
         for (int i = 0; i < btn_n; i++) begin
            state[i] <= filt_idle;
            cnt[i]   <= '0;
         end
      end else begin
         for (int i = 0; i < btn_n; i++) begin
            case (state[i])
               filt_idle: begin
                  cnt[i] <= '0;
                  if (sync_b[i] != level_n[i]) begin
                     state[i] <= filt_settle;          // change seen
                  end
               end
               filt_settle: begin
                  if (sync_b[i] == level_n[i]) begin
                     state[i] <= filt_idle;            // bounce, drop it
                  end else if (cnt[i] == '1) begin
                     level_n[i] <= sync_b[i];          // stable long enough
                     state[i]   <= filt_idle;
                  end else begin
                     cnt[i] <= cnt[i] + 1'b1;
                  end
               end
               default: state[i] <= filt_idle;
            endcase
         end
      end
   end

   assign pressed    = ~level_n;
   assign sys_reset  = pressed[0];
   assign halt_req   = pressed[1];
   assign term_reset = pressed[2];

   // timer switch, one flip per accepted press
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         timer_prev <= 1'b0;
         timer_on   <= 1'b0;
      end else begin
         timer_prev <= pressed[3];
         if (pressed[3] && !timer_prev) begin
            timer_on <= ~timer_on;
         end
      end
   end

   a_timer_toggle: assert property (@(posedge clk_p) disable iff (!arst_n)
      $changed(timer_on) |-> $past(pressed[3]) && !$past(pressed[3], 2));

endmodule : button_filter

`default_nettype wire

//--- hdl/dvk_board_pkg.sv
// shared widths and types for the board adaptation layer
// bus geometry, button count, DAC width, debounce length
// debouncer state type
`default_nettype none

package dvk_board_pkg;

   //******************************
   // memory bus geometry
   //******************************
   localparam int ram_aw = 15;          // word address, byte address bits 15:1
   localparam int ram_dw = 16;          // word width
   localparam int ram_sw = ram_dw / 8;  // byte select lanes

   //******************************
   // board controls
   //******************************
   localparam int btn_n = 4;            // active-low board buttons
   localparam int dac_w = 8;            // bits per DAC colour channel

   // level must hold for 2**debounce_w cycles
   // small value keeps simulation short, raise for the board
   localparam int debounce_w = 4;

   //******************************
   // debouncer state
   //******************************
   typedef enum logic {
      filt_idle,                        // level matches accepted value
      filt_settle                       // new level seen, counting
   } filt_state_t;

endpackage : dvk_board_pkg

`default_nettype wire

//--- hdl/dvk_board_top.sv
// board adaptation top
// memory bus slave, button conditioning, video DAC stage
// disk and timer LED mapping
`timescale 1ns/1ps
`default_nettype none

module dvk_board_top (
   input  logic                              clk_p,
   input  logic                              arst_n,
   // memory bus from the processor
   input  logic                              wb_cyc,
   input  logic                              wb_stb,
   input  logic                              wb_we,
   input  logic [dvk_board_pkg::ram_sw-1:0]  wb_sel,
   input  logic [dvk_board_pkg::ram_aw-1:0]  wb_adr,
   input  logic [dvk_board_pkg::ram_dw-1:0]  wb_dat_w,
   output logic [dvk_board_pkg::ram_dw-1:0]  wb_dat_r,
   output logic                              wb_ack,
   // buttons and controls
   input  logic [dvk_board_pkg::btn_n-1:0]   btn_n_in,
   output logic                              sys_reset,
   output logic                              halt_req,
   output logic                              term_reset,
   // disk activity and indicators
   input  logic                              rk_req,
   input  logic                              dw_req,
   input  logic                              my_req,
   input  logic                              dx_req,
   output logic [3:0]                        led,
   // video
   input  logic                              vga_red,
   input  logic                              vga_green,
   input  logic                              vga_blue,
   input  logic                              vga_hs_n,
   input  logic                              vga_vs_n,
   output logic [dvk_board_pkg::dac_w-1:0]   vgar,
   output logic [dvk_board_pkg::dac_w-1:0]   vgag,
   output logic [dvk_board_pkg::dac_w-1:0]   vgab,
   output logic                              vgah,
   output logic                              vgav,
   output logic                              vgablank
);

   logic timer_on;   // timer switch state, shown on led 3

   //******************************
   // on-chip memory
   //******************************
   ram_bus_slave u_ram_slave (
      .clk_p  (clk_p),
      .arst_n (arst_n),
      .cyc    (wb_cyc),
      .stb    (wb_stb),
      .we     (wb_we),
      .sel    (wb_sel),
      .adr    (wb_adr),
      .dat_w  (wb_dat_w),
      .dat_r  (wb_dat_r),
      .ack    (wb_ack)
   );

   //******************************
   // buttons
   //******************************
   button_filter u_buttons (
      .clk_p      (clk_p),
      .arst_n     (arst_n),
      .btn_n_in   (btn_n_in),
      .sys_reset  (sys_reset),
      .halt_req   (halt_req),
      .term_reset (term_reset),
      .timer_on   (timer_on)
   );

   //******************************
   // video DAC
   //******************************
   vga_dac_drive u_dac (
      .clk_p     (clk_p),
      .arst_n    (arst_n),
      .vga_red   (vga_red),
      .vga_green (vga_green),
      .vga_blue  (vga_blue),
      .vga_hs_n  (vga_hs_n),
      .vga_vs_n  (vga_vs_n),
      .vgar      (vgar),
      .vgag      (vgag),
      .vgab      (vgab),
      .vgah      (vgah),
      .vgav      (vgav),
      .vgablank  (vgablank)
   );

   // indicator LEDs
   assign led[0] = rk_req;            // rk disk request
   assign led[1] = dw_req;            // dw disk request
   assign led[2] = my_req | dx_req;   // my or dx disk request
   assign led[3] = timer_on;          // timer enabled

endmodule : dvk_board_top

`default_nettype wire

//--- hdl/ram_bus_slave.sv
// Wishbone classic slave in front of the on-chip RAM
// read and write strobes, two-stage delayed acknowledge
// bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module ram_bus_slave (
   input  logic                              clk_p,
   input  logic                              arst_n,
   input  logic                              cyc,
   input  logic                              stb,
   input  logic                              we,
   input  logic [dvk_board_pkg::ram_sw-1:0]  sel,
   input  logic [dvk_board_pkg::ram_aw-1:0]  adr,
   input  logic [dvk_board_pkg::ram_dw-1:0]  dat_w,
   output logic [dvk_board_pkg::ram_dw-1:0]  dat_r,
   output logic                              ack
);

   logic       req;       // cycle and strobe both active
   logic       rd_en;     // read strobe to RAM
   logic       wr_en;     // write strobe to RAM
   logic [1:0] stb_hist;  // strobe history, bit 1 = seen on two edges

   //******************************
   // strobes
   //******************************
   assign req   = cyc & stb;
   assign wr_en = req & we;
   assign rd_en = req & ~we;

   board_ram u_ram (
      .clk_p   (clk_p),
      .addr    (adr),
      .byte_en (sel),
      .wdata   (dat_w),
      .rd_en   (rd_en),
      .wr_en   (wr_en),
      .rdata   (dat_r)
   );

   //******************************
   // acknowledge delay
   //******************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         stb_hist <= 2'b00;
      end else begin
         stb_hist[0] <= req;                 // first edge of the strobe
         stb_hist[1] <= req & stb_hist[0];   // second edge, clears when stb drops
      end
   end

   assign ack = req & stb_hist[1];   // third cycle of the strobe, drops with stb

   //******************************
   // protocol checks
   //******************************
   // ack only after the strobe has been sampled on two earlier edges
   a_ack_after_stb: assert property (@(posedge clk_p) disable iff (!arst_n)
      $rose(ack) |-> stb && $past(stb) && $past(stb, 2));

   // master holds the request until ack is seen
   a_req_stable: assert property (@(posedge clk_p) disable iff (!arst_n)
      (req && !ack) |=> $stable(adr) && $stable(we) && $stable(dat_w) && $stable(sel));

   // a write must select at least one lane
   a_write_sel: assert property (@(posedge clk_p) disable iff (!arst_n)
      wr_en |-> sel != '0);

endmodule : ram_bus_slave

`default_nettype wire

//--- hdl/vga_dac_drive.sv
// video DAC output stage
// one register stage for colours and syncs
// 1-bit to 8-bit colour expansion, blanking during sync
`timescale 1ns/1ps
`default_nettype none

module vga_dac_drive (
   input  logic                             clk_p,
   input  logic                             arst_n,
   input  logic                             vga_red,
   input  logic                             vga_green,
   input  logic                             vga_blue,
   input  logic                             vga_hs_n,   // active-low hsync
   input  logic                             vga_vs_n,   // active-low vsync
   output logic [dvk_board_pkg::dac_w-1:0]  vgar,
   output logic [dvk_board_pkg::dac_w-1:0]  vgag,
   output logic [dvk_board_pkg::dac_w-1:0]  vgab,
   output logic                             vgah,
   output logic                             vgav,
   output logic                             vgablank    // low = blank
);
   import dvk_board_pkg::*;

   logic [2:0] rgb_q;     // r, g, b
   logic       hs_q;
   logic       vs_q;
   logic       blank_q;

   //******************************
   // alignment register
   //******************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         rgb_q   <= 3'b000;
         hs_q    <= 1'b1;              // syncs idle high
         vs_q    <= 1'b1;
         blank_q <= 1'b0;              // blanked in reset
      end else begin
         rgb_q   <= {vga_red, vga_green, vga_blue};
         hs_q    <= vga_hs_n;
         vs_q    <= vga_vs_n;
         blank_q <= vga_hs_n & vga_vs_n;   // blank during either sync
      end
   end

   assign vgar     = {dac_w{rgb_q[2]}};   // full scale or black
   assign vgag     = {dac_w{rgb_q[1]}};
   assign vgab     = {dac_w{rgb_q[0]}};
   assign vgah     = hs_q;
   assign vgav     = vs_q;
   assign vgablank = blank_q;

endmodule : vga_dac_drive

`default_nettype wire

//--- tests/tb_dvk_board.sv
// directed testbench for the board adaptation top
// memory bus transfers, byte lanes, button filtering
// video DAC stage and LED mapping checks
`timescale 1ns/1ps
`default_nettype none

module tb_dvk_board;
   import dvk_board_pkg::*;

   logic              clk_p;
   logic              arst_n;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [ram_sw-1:0] wb_sel;
   logic [ram_aw-1:0] wb_adr;
   logic [ram_dw-1:0] wb_dat_w;
   logic [ram_dw-1:0] wb_dat_r;
   logic              wb_ack;
   logic [btn_n-1:0]  btn_n_in;
   logic              sys_reset;
   logic              halt_req;
   logic              term_reset;
   logic              rk_req;
   logic              dw_req;
   logic              my_req;
   logic              dx_req;
   logic [3:0]        led;
   logic              vga_red;
   logic              vga_green;
   logic              vga_blue;
   logic              vga_hs_n;
   logic              vga_vs_n;
   logic [dac_w-1:0]  vgar;
   logic [dac_w-1:0]  vgag;
   logic [dac_w-1:0]  vgab;
   logic              vgah;
   logic              vgav;
   logic              vgablank;

   logic [31:0]       rng_state;         // xorshift state
   logic [ram_aw-1:0] addr_model [32];   // addresses written
   logic [ram_dw-1:0] word_model [32];   // expected memory contents

   dvk_board_top UUT (.*);

   initial begin
      clk_p = 1'b0;
      forever #10 clk_p = ~clk_p;   // 20 ns period
   end

   //******************************
   // helpers
   //******************************
   task automatic step_clock();
      @(posedge clk_p);
      #2;                           // drive and sample after the edge
   endtask

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Error at time %0t: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
         abort_run();
      end
   endtask

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // button-driven outputs by button number
   function automatic logic ctrl_out(input int idx);
      case (idx)
         0:       return sys_reset;
         1:       return halt_req;
         2:       return term_reset;
         default: return led[3];    // timer state
      endcase
   endfunction

   task automatic wait_output(input int idx, input logic val, input int limit,
                              output int cycles);
      for (cycles = 0; cycles < limit && ctrl_out(idx) !== val; cycles++) begin
         step_clock();
      end
      if (ctrl_out(idx) !== val) begin
         $display("button %0d output did not reach %0b within %0d cycles", idx, val, limit);
         abort_run();
      end
   endtask

   // one classic bus transfer, master side
   task automatic bus_cycle(input logic write, input logic [ram_sw-1:0] lanes,
                            input logic [ram_aw-1:0] addr, input logic [ram_dw-1:0] data,
                            output logic [ram_dw-1:0] rdata);
      int cycles;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = write;
      wb_sel   = lanes;
      wb_adr   = addr;
      wb_dat_w = data;
      for (cycles = 0; cycles < 8 && wb_ack !== 1'b1; cycles++) begin
         step_clock();
      end
      if (wb_ack !== 1'b1) begin
         $display("memory bus gave no acknowledge within 8 cycles");
         abort_run();
      end
      check_value(cycles, 2, "ack not in third strobe cycle");
      rdata = wb_dat_r;             // valid while ack is high
      step_clock();                 // ack seen on this edge
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      #1;
      check_value(wb_ack, 0, "ack after strobe drop");   // falls with stb
      step_clock();                 // one idle cycle
   endtask

   // DAC outputs for one set of r g b hs vs inputs
   task automatic check_dac_outputs(input logic [4:0] combo);
      check_value(vgar, combo[4] ? 8'hFF : 8'h00, "red channel");
      check_value(vgag, combo[3] ? 8'hFF : 8'h00, "green channel");
      check_value(vgab, combo[2] ? 8'hFF : 8'h00, "blue channel");
      check_value(vgah, combo[1], "hsync out");
      check_value(vgav, combo[0], "vsync out");
      check_value(vgablank, combo[1] && combo[0], "blank during sync");
   endtask

   //******************************
   // tests
   //******************************
   task automatic reset_state();
      check_value(wb_ack, 0, "wb_ack in reset");
      check_value(sys_reset, 0, "sys_reset in reset");
      check_value(halt_req, 0, "halt_req in reset");
      check_value(term_reset, 0, "term_reset in reset");
      check_value(led, 0, "led in reset");
      check_value(vgar, 0, "vgar in reset");
      check_value(vgag, 0, "vgag in reset");
      check_value(vgab, 0, "vgab in reset");
      check_value(vgablank, 0, "vgablank in reset");
      check_value(vgah, 1, "vgah in reset");
      check_value(vgav, 1, "vgav in reset");
   endtask

   task automatic word_write_read();
      logic [ram_dw-1:0] rd;
      for (int i = 0; i < 32; i++) begin
         rng_state     = next_random(rng_state);
         addr_model[i] = {rng_state[24:15], i[4:0]};   // low bits keep addresses unique
         rng_state     = next_random(rng_state);
         word_model[i] = rng_state[15:0];
         bus_cycle(1'b1, 2'b11, addr_model[i], word_model[i], rd);
      end
      for (int i = 0; i < 32; i++) begin
         bus_cycle(1'b0, 2'b11, addr_model[i], '0, rd);
         check_value(rd, word_model[i], "word readback");
      end
   endtask

   task automatic byte_lanes();
      logic [ram_dw-1:0] rd;
      logic [ram_dw-1:0] expected;
      expected = 16'hA55A;
      bus_cycle(1'b1, 2'b11, 15'h2A5C, expected, rd);
      bus_cycle(1'b1, 2'b01, 15'h2A5C, 16'h3CC3, rd);   // low lane only
      expected = {expected[15:8], 8'hC3};
      bus_cycle(1'b0, 2'b11, 15'h2A5C, '0, rd);
      check_value(rd, expected, "low lane write");
      bus_cycle(1'b1, 2'b10, 15'h2A5C, 16'h96E1, rd);   // high lane only
      expected = {8'h96, expected[7:0]};
      bus_cycle(1'b0, 2'b11, 15'h2A5C, '0, rd);
      check_value(rd, expected, "high lane write");
   endtask

   task automatic button_filtering();
      int cycles;
      for (int b = 0; b < 3; b++) begin
         btn_n_in[b] = 1'b0;                // short glitch
         repeat (10) step_clock();
         btn_n_in[b] = 1'b1;
         repeat (30) begin
            step_clock();
            check_value(ctrl_out(b), 0, "short pulse accepted");
         end
         btn_n_in[b] = 1'b0;                // real press
         wait_output(b, 1'b1, 30, cycles);
         check_value(cycles, 19, "press latency");   // 2 sync + 16 stable + 1
         repeat (40 - cycles) step_clock();
         btn_n_in[b] = 1'b1;
         wait_output(b, 1'b0, 30, cycles);
         check_value(cycles, 19, "release latency");
      end
      for (int n = 0; n < 2; n++) begin
         btn_n_in[3] = 1'b0;
         wait_output(3, n == 0, 30, cycles);        // on, then off
         check_value(cycles, 20, "timer toggle latency");
         repeat (40 - cycles) step_clock();
         btn_n_in[3] = 1'b1;
         repeat (30) begin
            step_clock();
            check_value(led[3], n == 0, "timer changed on release");
         end
      end
   endtask

   task automatic video_stage();
      logic [4:0] combo;   // r g b hs vs
      logic [4:0] prev;    // inputs registered on the last edge
      prev = 5'b00011;     // black, syncs idle high
      for (int c = 0; c < 32; c++) begin
         combo = c[4:0];
         {vga_red, vga_green, vga_blue, vga_hs_n, vga_vs_n} = combo;
         #1;
         check_dac_outputs(prev);   // new inputs not through the register yet
         step_clock();
         check_dac_outputs(combo);
         prev = combo;
      end
      {vga_red, vga_green, vga_blue} = 3'b000;
      vga_hs_n = 1'b1;
      vga_vs_n = 1'b1;
   endtask

   task automatic led_mapping();
      logic [3:0] req;     // rk dw my dx
      for (int c = 0; c < 16; c++) begin
         req = c[3:0];
         {rk_req, dw_req, my_req, dx_req} = req;
         step_clock();
         check_value(led[2:0], {req[1] | req[0], req[2], req[3]}, "disk led mapping");
         check_value(led[3], 0, "timer led");
      end
      {rk_req, dw_req, my_req, dx_req} = 4'b0000;
   endtask

   //******************************
   // main sequence
   //******************************
   initial begin
      arst_n    = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_sel    = '0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      btn_n_in  = '1;       // all released
      rk_req    = 1'b0;
      dw_req    = 1'b0;
      my_req    = 1'b0;
      dx_req    = 1'b0;
      vga_red   = 1'b0;
      vga_green = 1'b0;
      vga_blue  = 1'b0;
      vga_hs_n  = 1'b1;
      vga_vs_n  = 1'b1;
      rng_state = 32'd55;
      repeat (4) step_clock();
      reset_state();        // during reset
      repeat (4) step_clock();
      arst_n = 1'b1;
      #3;
      reset_state();        // right after release
      step_clock();
      word_write_read();
      byte_lanes();
      button_filtering();
      video_stage();
      led_mapping();
      $display("RESULT: PASS");
      $finish;
   end

endmodule : tb_dvk_board

`default_nettype wire
